// ==== logic/rf_settings.svh ====
// Register file size settings
// Depth, width and bank split of the 2048 by 16 two-port memory
`ifndef RF_SETTINGS_SVH
`define RF_SETTINGS_SVH

// Total number of words in the memory
`define RF_DEPTH 2048

// Data width of one word
`define RF_WIDTH 16

// Words held by one bank, the memory is built from two of them
`define RF_BANK_DEPTH 1024

// Full word address, the top bit picks the bank
`define RF_ADDR_W 11

// Address inside one bank
`define RF_BANK_ADDR_W 10

`endif

// ==== logic/rf_pkg.sv ====
// Register file types
// Request and power-control structs shared by the memory, the power
// sequencer and the subsystem top
`include "rf_settings.svh"

package rf_pkg;

    // ********************
    // Access requests
    // ********************

    // Write request, a single-cycle strobe that lands at the clock edge
    typedef struct packed {
        logic                  en;
        logic [`RF_ADDR_W-1:0] addr;
        logic [`RF_WIDTH-1:0]  data;
    } rf_wr_req_t;

    // Read request, data comes back one cycle after the strobe
    typedef struct packed {
        logic                  en;
        logic [`RF_ADDR_W-1:0] addr;
    } rf_rd_req_t;

    // ********************
    // Power control
    // ********************

    // Isolation clamps the bank outputs to zero
    // Enable_b high means the bank is switched off and only retains data
    typedef struct packed {
        logic isol_en;
        logic enable_b;
    } rf_pwr_ctl_t;

endpackage

// ==== logic/mem_reset_sync.sv ====
// Memory reset synchronizer
// Asserts asynchronously and releases after two clean rclk edges
`include "rf_settings.svh"

module mem_reset_sync (
    input  logic rclk,
    input  logic rclk_rst_n,
    output logic rst_n_sync
);

    // First stage may go metastable on release, the second one filters it
    logic rst_meta_q;

    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            rst_meta_q <= 1'b0;
            rst_n_sync <= 1'b0;
        end else begin
            // A constant one shifts in once reset is gone
            rst_meta_q <= 1'b1;
            rst_n_sync <= rst_meta_q;
        end
    end

endmodule

// ==== logic/rf_bank.sv ====
// One 1024 by 16 register file bank
// Registered read, write gating on the bank power state, output isolation
// and one registered stage of the power-enable daisy chain
`include "rf_settings.svh"

module rf_bank (
    input  logic                         rclk,
    input  logic                         rst_n,
    input  logic                         we,
    input  logic [`RF_BANK_ADDR_W-1:0]   waddr,
    input  logic [`RF_WIDTH-1:0]         wdata,
    input  logic                         re,
    input  logic [`RF_BANK_ADDR_W-1:0]   raddr,
    output logic [`RF_WIDTH-1:0]         rdata,
    input  rf_pkg::rf_pwr_ctl_t          pwr_ctl,
    input  logic                         pwr_enable_b_in,
    output logic                         pwr_enable_b_out
);

    // ********************
    // Storage
    // ********************

    logic [`RF_WIDTH-1:0] mem [`RF_BANK_DEPTH];

    // Read register, holds the last word read until the next read
    logic [`RF_WIDTH-1:0] rd_q;

    // High when the array may be written
    logic                 wr_allow;

    // The bank follows its own chain stage, so a bank that is still off
    // drops writes even if the request arrives early
    // Isolation also clamps the write port while the array powers down
    assign wr_allow = ~pwr_enable_b_out & ~pwr_ctl.isol_en;

    // Read and write share one edge, so a read of the address being
    // written picks up the old word
    always_ff @(posedge rclk) begin
        if (we && wr_allow) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rd_q <= mem[raddr];
        end
    end

    // Clamp the output to zero while isolated, the array keeps its contents
    assign rdata = pwr_ctl.isol_en ? '0 : rd_q;

    // ********************
    // Power chain stage
    // ********************

    // One flop per bank, so the enable walks down the chain one bank per cycle
    // During reset the bank counts as off
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_enable_b_out <= 1'b1;
        end else begin
            pwr_enable_b_out <= pwr_enable_b_in;
        end
    end

endmodule

// ==== logic/rf_2p_2048x16.sv ====
// Two-port 2048 by 16 register file
// Built from two 1024-word banks, the top address bit selects the bank
// A registered bank select steers the read data back out, and the power
// enable runs through bank 0 and then bank 1
`include "rf_settings.svh"

module rf_2p_2048x16 (
    input  logic                  rclk,
    input  logic                  rst_n,
    input  rf_pkg::rf_wr_req_t    wr_req,
    input  rf_pkg::rf_rd_req_t    rd_req,
    input  rf_pkg::rf_pwr_ctl_t   pwr_ctl,
    output logic [`RF_WIDTH-1:0]  rdata,
    output logic                  rd_valid,
    output logic                  pwr_enable_b_out
);

    // ********************
    // Bank decode
    // ********************

    // One enable bit per bank
    logic [1:0] we_sel;
    logic [1:0] re_sel;

    // Bank of the most recent read, kept so rdata holds between reads
    logic       rd_sel_q;

    // Per-bank read data
    logic [`RF_WIDTH-1:0] bank0_rdata;
    logic [`RF_WIDTH-1:0] bank1_rdata;

    // Enable_b at the input of each bank and at the end of the chain
    logic [2:0] pwr_chain;

    assign we_sel[1] = wr_req.en &  wr_req.addr[`RF_ADDR_W-1];
    assign we_sel[0] = wr_req.en & ~wr_req.addr[`RF_ADDR_W-1];
    assign re_sel[1] = rd_req.en &  rd_req.addr[`RF_ADDR_W-1];
    assign re_sel[0] = rd_req.en & ~rd_req.addr[`RF_ADDR_W-1];

    // Select and valid line up with the registered bank read
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_sel_q   <= 1'b0;
            rd_valid   <= 1'b0;
        end else begin
            rd_valid <= rd_req.en;
            if (rd_req.en) begin
                rd_sel_q <= re_sel[1];
            end
        end
    end

    // ********************
    // Banks
    // ********************

    assign pwr_chain[0] = pwr_ctl.enable_b;

    rf_bank u_bank0 (
        .rclk             (rclk),
        .rst_n            (rst_n),
        .we               (we_sel[0]),
        .waddr            (wr_req.addr[`RF_BANK_ADDR_W-1:0]),
        .wdata            (wr_req.data),
        .re               (re_sel[0]),
        .raddr            (rd_req.addr[`RF_BANK_ADDR_W-1:0]),
        .rdata            (bank0_rdata),
        .pwr_ctl          (pwr_ctl),
        .pwr_enable_b_in  (pwr_chain[0]),
        .pwr_enable_b_out (pwr_chain[1])
    );

    rf_bank u_bank1 (
        .rclk             (rclk),
        .rst_n            (rst_n),
        .we               (we_sel[1]),
        .waddr            (wr_req.addr[`RF_BANK_ADDR_W-1:0]),
        .wdata            (wr_req.data),
        .re               (re_sel[1]),
        .raddr            (rd_req.addr[`RF_BANK_ADDR_W-1:0]),
        .rdata            (bank1_rdata),
        .pwr_ctl          (pwr_ctl),
        .pwr_enable_b_in  (pwr_chain[1]),
        .pwr_enable_b_out (pwr_chain[2])
    );

    // The enable comes back only after both banks have switched
    assign pwr_enable_b_out = pwr_chain[2];

    // Output mux on the registered bank select
    assign rdata = rd_sel_q ? bank1_rdata : bank0_rdata;

endmodule

// ==== logic/rf_pwr_ctrl.sv ====
// Register file power controller
// Holds the power-off configuration bit and sequences isolation and the
// power enable, waiting for the enable to return through the bank chain
`include "rf_settings.svh"

module rf_pwr_ctrl (
    input  logic                 rclk,
    input  logic                 rclk_rst_n,
    input  logic                 cfg_wr,
    input  logic                 cfg_pwr_off,
    input  logic                 pwr_enable_b_out,
    output rf_pkg::rf_pwr_ctl_t  pwr_ctl,
    output logic                 pwr_ready
);

    typedef enum logic [1:0] {
        ST_ON      = 2'd0,
        ST_ISOLATE = 2'd1,
        ST_OFF     = 2'd2,
        ST_WAKE    = 2'd3
    } pwr_state_t;

    pwr_state_t           state_q;
    rf_pkg::rf_pwr_ctl_t  pwr_ctl_q;
    logic                 pwr_ready_q;

    // Configuration register, one means the memory should be off
    logic                 pwr_off_q;

    // Newest requested setting, a strobe in this cycle wins over the register
    logic                 target_off;

    assign target_off = cfg_wr ? cfg_pwr_off : pwr_off_q;

    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            pwr_off_q <= 1'b0;
        end else if (cfg_wr) begin
            pwr_off_q <= cfg_pwr_off;
        end
    end

    // ********************
    // Sequencer
    // ********************

    // Reset starts in WAKE with isolation low, so ready rises once the
    // synchronized bank reset has released and the chain reads low
    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            state_q            <= ST_WAKE;
            pwr_ctl_q.isol_en  <= 1'b0;
            pwr_ctl_q.enable_b <= 1'b0;
            pwr_ready_q        <= 1'b0;
        end else begin
            case (state_q)
                ST_ON: begin
                    // Clamp the outputs first, power comes off a cycle later
                    if (target_off) begin
                        pwr_ctl_q.isol_en <= 1'b1;
                        pwr_ready_q       <= 1'b0;
                        state_q           <= ST_ISOLATE;
                    end
                end
                ST_ISOLATE: begin
                    // This step always completes, a newer setting is seen in OFF
                    pwr_ctl_q.enable_b <= 1'b1;
                    state_q            <= ST_OFF;
                end
                ST_OFF: begin
                    // Release the enable and keep isolation until the chain returns
                    if (!target_off) begin
                        pwr_ctl_q.enable_b <= 1'b0;
                        state_q            <= ST_WAKE;
                    end
                end
                ST_WAKE: begin
                    if (!pwr_enable_b_out) begin
                        if (target_off) begin
                            // Banks are up but off was asked for meanwhile
                            pwr_ctl_q.isol_en <= 1'b1;
                            state_q           <= ST_ISOLATE;
                        end else begin
                            pwr_ctl_q.isol_en <= 1'b0;
                            pwr_ready_q       <= 1'b1;
                            state_q           <= ST_ON;
                        end
                    end
                end
                default: begin
                    state_q <= ST_WAKE;
                end
            endcase
        end
    end

    assign pwr_ctl   = pwr_ctl_q;
    assign pwr_ready = pwr_ready_q;

endmodule

// ==== logic/rf_subsys_top.sv ====
// Register file subsystem top
// Ties the power controller and the memory reset synchronizer to the
// two-bank power-gated register file
`include "rf_settings.svh"

module rf_subsys_top (
    input  logic                  rclk,
    input  logic                  rclk_rst_n,
    input  rf_pkg::rf_wr_req_t    wr_req,
    input  rf_pkg::rf_rd_req_t    rd_req,
    input  logic                  cfg_wr,
    input  logic                  cfg_pwr_off,
    output logic [`RF_WIDTH-1:0]  rdata,
    output logic                  rd_valid,
    output logic                  pwr_ready
);

    // Synchronized reset for the bank logic
    logic                 mem_rst_n;

    // Isolation and enable from the controller into the memory
    rf_pkg::rf_pwr_ctl_t  pwr_ctl;

    // Enable after both bank stages, read back by the controller
    logic                 pwr_enable_b_out;

    mem_reset_sync u_mem_reset_sync (
        .rclk       (rclk),
        .rclk_rst_n (rclk_rst_n),
        .rst_n_sync (mem_rst_n)
    );

    rf_pwr_ctrl u_rf_pwr_ctrl (
        .rclk             (rclk),
        .rclk_rst_n       (rclk_rst_n),
        .cfg_wr           (cfg_wr),
        .cfg_pwr_off      (cfg_pwr_off),
        .pwr_enable_b_out (pwr_enable_b_out),
        .pwr_ctl          (pwr_ctl),
        .pwr_ready        (pwr_ready)
    );

    rf_2p_2048x16 u_rf_2p_2048x16 (
        .rclk             (rclk),
        .rst_n            (mem_rst_n),
        .wr_req           (wr_req),
        .rd_req           (rd_req),
        .pwr_ctl          (pwr_ctl),
        .rdata            (rdata),
        .rd_valid         (rd_valid),
        .pwr_enable_b_out (pwr_enable_b_out)
    );

endmodule

// ==== testbench/tb_clk_gen.sv ====
// Testbench clock and reset source
// Free-running clock with a period of 8 and a reset held for 5 cycles

module tb_clk_gen (
    output logic rclk,
    output logic rclk_rst_n
);

    initial begin
        rclk = 1'b0;
        forever #4 rclk = ~rclk;
    end

    // Reset releases on a rising edge, like any other driven input
    initial begin
        rclk_rst_n = 1'b0;
        repeat (5) @(posedge rclk);
        rclk_rst_n <= 1'b1;
    end

endmodule

// ==== testbench/tb_rf_subsys.sv ====
// Register file subsystem testbench
// Directed tests for writes, reads, pipelined access and power gating,
// each checked against a shadow copy of the 2048-word memory
`include "rf_settings.svh"

module tb_rf_subsys;

    logic                  rclk;
    logic                  rclk_rst_n;
    rf_pkg::rf_wr_req_t    wr_req;
    rf_pkg::rf_rd_req_t    rd_req;
    logic                  cfg_wr;
    logic                  cfg_pwr_off;
    logic [`RF_WIDTH-1:0]  rdata;
    logic                  rd_valid;
    logic                  pwr_ready;

    // Expected memory contents that follow only the writes the DUT accepts
    logic [`RF_WIDTH-1:0]  shadow [`RF_DEPTH];

    // Read strobed in the previous cycle and checked one cycle later
    logic                  pend_rd;
    logic [`RF_ADDR_W-1:0] pend_addr;
    logic [`RF_WIDTH-1:0]  pend_exp;

    // Last word returned, which rdata should hold until the next read
    logic                  have_last;
    logic [`RF_WIDTH-1:0]  last_exp;

    // High while the memory is isolated and reads come back as zero
    logic                  mem_off;

    integer                seed;

    tb_clk_gen u_tb_clk_gen (
        .rclk       (rclk),
        .rclk_rst_n (rclk_rst_n)
    );

    rf_subsys_top u_rf_subsys_top (
        .rclk        (rclk),
        .rclk_rst_n  (rclk_rst_n),
        .wr_req      (wr_req),
        .rd_req      (rd_req),
        .cfg_wr      (cfg_wr),
        .cfg_pwr_off (cfg_pwr_off),
        .rdata       (rdata),
        .rd_valid    (rd_valid),
        .pwr_ready   (pwr_ready)
    );

    // ********************
    // Helpers
    // ********************

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at time %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // Word pattern that involves all eleven address bits
    function automatic logic [`RF_WIDTH-1:0] fill_word(input logic [`RF_ADDR_W-1:0] a);
        return {a[4:0], a};
    endfunction

    // Waits at falling edges until pwr_ready reaches a level while no read is in flight
    task automatic wait_ready(input logic level, input int limit, input string what);
        int n;
        for (n = 0; n <= limit; n++) begin
            @(negedge rclk);
            check_eq(32'(rd_valid), 32'd0, "rd_valid without a read");
            if (pwr_ready === level) begin
                break;
            end
        end
        if (pwr_ready !== level) begin
            $display("Timeout at time %0t: %s", $time, what);
            stop_with_failure();
        end
    endtask

    // One clock cycle of traffic
    // The strobes go out on the rising edge and the read from the cycle
    // before is checked at the falling edge
    task automatic step(
        input logic                  do_wr,
        input logic [`RF_ADDR_W-1:0] waddr,
        input logic [`RF_WIDTH-1:0]  wdata,
        input logic                  do_rd,
        input logic [`RF_ADDR_W-1:0] raddr
    );
        logic [`RF_WIDTH-1:0] exp_now;
        // Expected word is taken before this cycle's write touches the shadow
        exp_now = mem_off ? '0 : shadow[raddr];
        @(posedge rclk);
        wr_req.en   <= do_wr;
        wr_req.addr <= waddr;
        wr_req.data <= wdata;
        rd_req.en   <= do_rd;
        rd_req.addr <= raddr;
        @(negedge rclk);
        // A write counts only when the memory is ready in its strobe cycle
        if (do_wr && pwr_ready) begin
            shadow[waddr] = wdata;
        end
        check_eq(32'(rd_valid), 32'(pend_rd), "rd_valid one cycle after the strobe");
        if (pend_rd) begin
            check_eq(32'(rdata), 32'(pend_exp), $sformatf("rdata for address %0d", pend_addr));
            have_last = 1'b1;
            last_exp  = pend_exp;
        end else if (have_last) begin
            check_eq(32'(rdata), 32'(last_exp), "rdata held between reads");
        end
        pend_rd   = do_rd;
        pend_addr = raddr;
        pend_exp  = exp_now;
    endtask

    task automatic idle_cycle();
        step(1'b0, 11'd0, 16'd0, 1'b0, 11'd0);
    endtask

    // Single-cycle configuration strobe
    task automatic write_cfg(input logic off);
        @(posedge rclk);
        cfg_wr      <= 1'b1;
        cfg_pwr_off <= off;
        @(posedge rclk);
        cfg_wr      <= 1'b0;
    endtask

    // ********************
    // Tests
    // ********************

    task automatic reset_release();
        wait_ready(1'b1, 40, "pwr_ready did not rise after reset");
    endtask

    task automatic corner_write_read();
        logic [`RF_ADDR_W-1:0] corner [6];
        int                    i;
        // Fill the whole array so every later readback has a known word
        for (i = 0; i < `RF_DEPTH; i++) begin
            step(1'b1, 11'(i), fill_word(11'(i)), 1'b0, 11'd0);
        end
        corner[0] = 11'd0;
        corner[1] = 11'd1023;
        corner[2] = 11'd1024;
        corner[3] = 11'd2047;
        corner[4] = 11'd1;
        corner[5] = 11'd1025;
        // Bank edges in both halves with each read checked in the very next cycle
        for (i = 0; i < 6; i++) begin
            step(1'b1, corner[i], 16'hc35a ^ {5'd0, corner[i]}, 1'b0, 11'd0);
            step(1'b0, 11'd0, 16'd0, 1'b1, corner[i]);
            idle_cycle();
        end
    endtask

    task automatic back_to_back_reads();
        int i;
        // Bit 0 of the count picks the bank, so the banks alternate every cycle
        for (i = 0; i < 64; i++) begin
            step(1'b0, 11'd0, 16'd0, 1'b1, {i[0], 10'(i * 37)});
        end
        idle_cycle();
    endtask

    task automatic random_traffic();
        logic [31:0]           rnd_a;
        logic [31:0]           rnd_b;
        logic [`RF_ADDR_W-1:0] waddr;
        logic [`RF_ADDR_W-1:0] raddr;
        logic                  do_wr;
        logic                  do_rd;
        int                    i;
        for (i = 0; i < 200; i++) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            waddr = rnd_a[10:0];
            raddr = rnd_b[10:0];
            do_wr = rnd_b[16];
            do_rd = rnd_b[17];
            // Every eighth cycle reads the address being written and expects old data
            if (i % 8 == 0) begin
                do_wr = 1'b1;
                do_rd = 1'b1;
                raddr = waddr;
            end
            step(do_wr, waddr, rnd_a[26:11], do_rd, raddr);
        end
        idle_cycle();
    endtask

    task automatic power_off_retention();
        write_cfg(1'b1);
        wait_ready(1'b0, 10, "pwr_ready did not fall after the power-off request");
        mem_off   = 1'b1;
        have_last = 1'b0;
        step(1'b0, 11'd0, 16'd0, 1'b1, 11'd0);
        step(1'b0, 11'd0, 16'd0, 1'b1, 11'd2047);
        // One write into each bank and both must be dropped
        step(1'b1, 11'd100, 16'hdead, 1'b0, 11'd0);
        step(1'b1, 11'd1900, 16'hbeef, 1'b1, 11'd1024);
        idle_cycle();
        check_eq(32'(pwr_ready), 32'd0, "pwr_ready while powered off");
    endtask

    task automatic power_on_restore();
        int i;
        write_cfg(1'b0);
        wait_ready(1'b1, 20, "pwr_ready did not return after the power-on request");
        mem_off   = 1'b0;
        have_last = 1'b0;
        // The addresses written while off come first, then the whole array
        step(1'b0, 11'd0, 16'd0, 1'b1, 11'd100);
        step(1'b0, 11'd0, 16'd0, 1'b1, 11'd1900);
        for (i = 0; i < `RF_DEPTH; i++) begin
            step(1'b0, 11'd0, 16'd0, 1'b1, 11'(i));
        end
        idle_cycle();
        // Writes land again once the memory is back on
        step(1'b1, 11'd100, 16'h600d, 1'b0, 11'd0);
        step(1'b0, 11'd0, 16'd0, 1'b1, 11'd100);
        idle_cycle();
    endtask

    // ********************
    // Sequence
    // ********************

    initial begin
        wr_req      = '0;
        rd_req      = '0;
        cfg_wr      = 1'b0;
        cfg_pwr_off = 1'b0;
        seed        = 32'h3d0f;
        mem_off     = 1'b0;
        pend_rd     = 1'b0;
        pend_addr   = '0;
        pend_exp    = '0;
        have_last   = 1'b0;
        last_exp    = '0;

        reset_release();
        corner_write_read();
        back_to_back_reads();
        random_traffic();
        power_off_retention();
        power_on_restore();

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+logic
logic/rf_pkg.sv
logic/mem_reset_sync.sv
logic/rf_bank.sv
logic/rf_2p_2048x16.sv
logic/rf_pwr_ctrl.sv
logic/rf_subsys_top.sv
testbench/tb_clk_gen.sv
testbench/tb_rf_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the register file subsystem testbench with Verilator and runs it

FAIL_MSG="TEST FAILED"
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rf_subsys -f compile.f -Mdir obj_dir -o tb_rf_subsys
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rf_subsys > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation passed"
exit 0
